// File: hw/credit_sizing_pkg.sv
/* Credit pool sizing package
   Number of freelists, counter and index widths, and the credit count after reset */
package credit_sizing_pkg;

  // Number of freelists in the pool; the selector tree is built for exactly eight
  localparam int num_lists = 8;

  // Bits in each free-credit counter
  localparam int cnt_width = 12;

  // Bits needed to name one freelist
  localparam int idx_width = 3;

  // Count every freelist holds when reset is released
  localparam int init_credits = 4;

  // Largest count a counter can hold, all ones at the counter width
  localparam logic [cnt_width-1:0] max_credits = '1;

  // All counts side by side, list 0 in the lowest slice
  typedef logic [num_lists-1:0][cnt_width-1:0] cnt_vec_t;

endpackage

// File: hw/credit_xact_pkg.sv
/* Credit pool transaction package
   Handshake payloads, counter update command and the grant controller state encoding */
package credit_xact_pkg;

  import credit_sizing_pkg::*;

  // Allocate response, valid while alloc_ack is high
  // The ok bit is low when every freelist was empty
  typedef struct packed {
    logic [idx_width-1:0] idx;
    logic                 ok;
  } alloc_rsp_t;

  // Release request names the freelist the credit goes back to
  typedef struct packed {
    logic [idx_width-1:0] idx;
  } release_req_t;

  // One decrement and one increment per cycle, controller to counters
  typedef struct packed {
    logic                 dec_en;
    logic [idx_width-1:0] dec_idx;
    logic                 inc_en;
    logic [idx_width-1:0] inc_idx;
  } cnt_update_t;

  // Grant controller states
  typedef enum logic [1:0] {
    st_idle        = 2'd0,
    st_alloc_ack   = 2'd1,
    st_release_ack = 2'd2
  } grant_state_e;

endpackage

// File: hw/freelist_select.sv
/* Freelist selector
   Registered comparator tree naming the list with the most free credits, lower index on ties */
module freelist_select
  import credit_sizing_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  cnt_vec_t             counts,
  output logic                 winner_v,
  output logic [idx_width-1:0] winner
);

  // First level holds four pair winners, second level two
  logic [cnt_width-1:0] l1_cnt [4];
  logic [idx_width-1:0] l1_idx [4];
  logic [cnt_width-1:0] l2_cnt [2];
  logic [idx_width-1:0] l2_idx [2];
  logic                 final_ge;
  logic [idx_width-1:0] winner_d;
  logic                 winner_v_d;
  logic [idx_width-1:0] winner_q;
  logic                 winner_v_q;

  // Lists 0/1, 2/3, 4/5 and 6/7 are compared first
  // Greater-or-equal keeps the even, lower index when the counts tie
  for (genvar i = 0; i < 4; i++) begin : g_level1
    logic ge;
    assign ge        = (counts[2*i] >= counts[2*i+1]);
    assign l1_cnt[i] = ge ? counts[2*i] : counts[2*i+1];
    assign l1_idx[i] = ge ? idx_width'(2*i) : idx_width'(2*i+1);
  end

  // Pair winners meet next, again favouring the left side on a tie
  for (genvar j = 0; j < 2; j++) begin : g_level2
    logic ge;
    assign ge        = (l1_cnt[2*j] >= l1_cnt[2*j+1]);
    assign l2_cnt[j] = ge ? l1_cnt[2*j] : l1_cnt[2*j+1];
    assign l2_idx[j] = ge ? l1_idx[2*j] : l1_idx[2*j+1];
  end

  // Lists 0..3 against lists 4..7
  assign final_ge = (l2_cnt[0] >= l2_cnt[1]);
  assign winner_d = final_ge ? l2_idx[0] : l2_idx[1];

  // A winner is only usable when some list still has a credit
  assign winner_v_d = |counts;

  // One cycle of latency from counts to winner
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      winner_v_q <= 1'b0;
      winner_q   <= '0;
    end else begin
      winner_v_q <= winner_v_d;
      winner_q   <= winner_d;
    end
  end

  assign winner_v = winner_v_q;
  assign winner   = winner_q;

endmodule

// File: hw/freelist_counters.sv
/* Freelist credit counters
   Eight saturating free-credit counts with one decrement and one increment port */
module freelist_counters
  import credit_sizing_pkg::*;
  import credit_xact_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  cnt_update_t cnt_update,
  output cnt_vec_t    counts
);

  cnt_vec_t counts_q;

  for (genvar i = 0; i < num_lists; i++) begin : g_cnt
    logic dec_hit;
    logic inc_hit;
    logic can_dec;
    logic can_inc;

    // Decode which ports target this list
    assign dec_hit = cnt_update.dec_en && (cnt_update.dec_idx == idx_width'(i));
    assign inc_hit = cnt_update.inc_en && (cnt_update.inc_idx == idx_width'(i));

    // Limits keep the count inside 0..max_credits even on a bad command
    assign can_dec = (counts_q[i] != '0);
    assign can_inc = (counts_q[i] != max_credits);

    // The update lands on the edge where cnt_update is sampled
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        counts_q[i] <= cnt_width'(init_credits);
      end else begin
        // A decrement and an increment on the same list cancel out
        if (dec_hit && !inc_hit && can_dec) begin
          counts_q[i] <= counts_q[i] - 1'b1;
        end else if (inc_hit && !dec_hit && can_inc) begin
          counts_q[i] <= counts_q[i] + 1'b1;
        end
      end
    end
  end

  // Counts go to the selector and back to the controller for the full check
  assign counts = counts_q;

endmodule

// File: hw/credit_grant_ctrl.sv
/* Credit grant controller
   Serves the allocate and release four-phase handshakes and issues the counter updates */
module credit_grant_ctrl
  import credit_sizing_pkg::*;
  import credit_xact_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 alloc_req,
  output logic                 alloc_ack,
  output alloc_rsp_t           alloc_rsp,
  input  logic                 release_req,
  input  release_req_t         release_info,
  output logic                 release_ack,
  output logic                 release_ok,
  input  cnt_vec_t             counts,
  input  logic                 winner_v,
  input  logic [idx_width-1:0] winner,
  output cnt_update_t          cnt_update
);

  grant_state_e state_q;
  grant_state_e state_d;
  logic         take_alloc;
  logic         take_release;
  logic         rel_ok;
  logic         alloc_ack_q;
  logic         release_ack_q;
  alloc_rsp_t   alloc_rsp_q;
  logic         release_ok_q;

  // A handshake is accepted only in idle, and release wins when both arrive together
  assign take_release = (state_q == st_idle) && release_req;
  assign take_alloc   = (state_q == st_idle) && alloc_req && !release_req;

  // The named list can take the credit back unless it is already full
  assign rel_ok = (counts[release_info.idx] != max_credits);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (release_req) begin
          state_d = st_release_ack;
        end else if (alloc_req) begin
          state_d = st_alloc_ack;
        end
      end
      // Stay in ack until the client drops its request
      st_alloc_ack: begin
        if (!alloc_req) begin
          state_d = st_idle;
        end
      end
      st_release_ack: begin
        if (!release_req) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  // Count updates are issued in the accepting idle cycle so they land with the ack edge
  // An empty pool gives no decrement, a full list gives no increment
  always_comb begin
    cnt_update         = '0;
    cnt_update.dec_en  = take_alloc && winner_v;
    cnt_update.dec_idx = winner;
    cnt_update.inc_en  = take_release && rel_ok;
    cnt_update.inc_idx = release_info.idx;
  end

  // Control state and the registered acks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= st_idle;
      alloc_ack_q   <= 1'b0;
      release_ack_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      alloc_ack_q   <= (state_d == st_alloc_ack);
      release_ack_q <= (state_d == st_release_ack);
    end
  end

  // Response payloads are captured at acceptance and held through the ack phase
  always_ff @(posedge clk) begin
    if (take_alloc) begin
      alloc_rsp_q.idx <= winner;
      alloc_rsp_q.ok  <= winner_v;
    end
    if (take_release) begin
      release_ok_q <= rel_ok;
    end
  end

  assign alloc_ack   = alloc_ack_q;
  assign alloc_rsp   = alloc_rsp_q;
  assign release_ack = release_ack_q;
  assign release_ok  = release_ok_q;

endmodule

// File: hw/credit_pool_top.sv
/* Credit freelist pool
   Joins the credit counters, the most-credits selector and the grant controller */
module credit_pool_top
  import credit_sizing_pkg::*;
  import credit_xact_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         alloc_req,
  output logic         alloc_ack,
  output alloc_rsp_t   alloc_rsp,
  input  logic         release_req,
  input  release_req_t release_info,
  output logic         release_ack,
  output logic         release_ok
);

  // Counts feed the selector and the controller's release check
  cnt_vec_t             counts;
  cnt_update_t          cnt_update;
  logic                 winner_v;
  logic [idx_width-1:0] winner;

  freelist_counters u_counters (
    .clk        (clk),
    .rst_n      (rst_n),
    .cnt_update (cnt_update),
    .counts     (counts)
  );

  freelist_select u_select (
    .clk      (clk),
    .rst_n    (rst_n),
    .counts   (counts),
    .winner_v (winner_v),
    .winner   (winner)
  );

  credit_grant_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_req    (alloc_req),
    .alloc_ack    (alloc_ack),
    .alloc_rsp    (alloc_rsp),
    .release_req  (release_req),
    .release_info (release_info),
    .release_ack  (release_ack),
    .release_ok   (release_ok),
    .counts       (counts),
    .winner_v     (winner_v),
    .winner       (winner),
    .cnt_update   (cnt_update)
  );

endmodule

// File: testbench/credit_pool_assertions.sv
/* Grant controller assertions
   Four-phase handshake order, exclusive acks and decrements only of a list that holds a credit */
module credit_pool_assertions
  import credit_sizing_pkg::*;
  import credit_xact_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        alloc_req,
  input logic        alloc_ack,
  input logic        release_req,
  input logic        release_ack,
  input logic        winner_v,
  input cnt_vec_t    counts,
  input cnt_update_t cnt_update
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // An ack only rises after its own request was seen
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(alloc_ack) |-> $past(alloc_req)) and
    ($rose(release_ack) |-> $past(release_req)))
    else begin
      fail_count++;
      $error("An ack rose without its request");
    end

  // The ack drops on the edge after the request is seen low
  ack_follows_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
    ($fell(alloc_req) |=> !alloc_ack) and ($fell(release_req) |=> !release_ack))
    else begin
      fail_count++;
      $error("An ack stayed high after its request fell");
    end

  acks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(alloc_ack && release_ack))
    else begin
      fail_count++;
      $error("alloc_ack and release_ack are high together");
    end

  // A decrement needs a valid winner, and a stale winner would hit a list with no credit left
  dec_needs_winner: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_update.dec_en |-> (winner_v && (counts[cnt_update.dec_idx] != '0)))
    else begin
      fail_count++;
      $error("A counter decrement was issued without a valid winner or on an empty list");
    end

endmodule

// File: testbench/credit_pool_checker.sv
/* Credit pool checker
   Reference count model that checks every allocate and release response of the DUT */
module credit_pool_checker
  import credit_sizing_pkg::*;
  import credit_xact_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         alloc_req,
  input  logic         alloc_ack,
  input  alloc_rsp_t   alloc_rsp,
  input  logic         release_req,
  input  release_req_t release_info,
  input  logic         release_ack,
  input  logic         release_ok,
  output int           mismatch_count,
  output int           protocol_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [cnt_width-1:0] model [num_lists];
  logic                 alloc_req_d;
  logic                 alloc_ack_d;
  logic                 release_req_d;
  logic                 release_ack_d;

  initial begin
    mismatch_count = 0;
    protocol_count = 0;
  end

  // The grant should be the lowest index among the largest counts
  task automatic check_alloc();
    int best;
    best = 0;
    for (int i = 1; i < num_lists; i++) begin
      if (model[i] > model[best]) best = i;
    end
    if (release_req) begin
      protocol_count++;
      $display("An allocation was granted while a release request was still waiting");
    end
    if (alloc_rsp.ok !== (model[best] != 0)) begin
      mismatch_count++;
      $display("Mismatch alloc_rsp.ok: got 0x%0h, expected 0x%0h", alloc_rsp.ok, model[best] != 0);
    end else if (alloc_rsp.ok && alloc_rsp.idx !== idx_width'(best)) begin
      mismatch_count++;
      $display("Mismatch alloc_rsp.idx: got 0x%0h, expected 0x%0h", alloc_rsp.idx, best);
    end
    if (model[best] != 0) model[best]--;
  endtask

  // A full list refuses the credit
  task automatic check_release();
    logic exp_ok;
    exp_ok = (model[release_info.idx] != max_credits);
    if (release_ok !== exp_ok) begin
      mismatch_count++;
      $display("Mismatch release_ok: got 0x%0h, expected 0x%0h", release_ok, exp_ok);
    end
    if (exp_ok) model[release_info.idx]++;
  endtask

  // Sampled at the rising edge, so every value is the one settled in the cycle before
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      foreach (model[i]) model[i] = cnt_width'(init_credits);
      {alloc_req_d, alloc_ack_d, release_req_d, release_ack_d} = '0;
    end else begin
      // A request must be acked one cycle later unless the other handshake holds the FSM
      if ((alloc_req_d && !alloc_ack_d && !alloc_ack && !release_req_d && !release_ack_d) ||
          (release_req_d && !release_ack_d && !release_ack && !alloc_ack_d)) begin
        protocol_count++;
        $display("An ack did not rise one cycle after its request");
      end
      if (alloc_ack && !alloc_ack_d) check_alloc();
      if (release_ack && !release_ack_d) check_release();
      {alloc_req_d, alloc_ack_d, release_req_d, release_ack_d} =
        {alloc_req, alloc_ack, release_req, release_ack};
    end
  end

endmodule

// File: testbench/credit_pool_tb.sv
/* Credit pool testbench
   Replays the stim file over both handshakes and prints the closing result */
module credit_pool_tb
  import credit_sizing_pkg::*;
  import credit_xact_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 3;

  logic         clk;
  logic         rst_n;
  logic         alloc_req;
  logic         alloc_ack;
  alloc_rsp_t   alloc_rsp;
  logic         release_req;
  release_req_t release_info;
  logic         release_ack;
  logic         release_ok;
  int           mismatch_count;
  int           protocol_count;
  int           cycle_limit = 0;

  // One entry per operation line of the stim file
  byte op_q[$];
  int  arg_q[$];
  int  idle_q[$];

  credit_pool_top u_dut (.*);

  credit_pool_checker u_checker (.*);

  bind credit_grant_ctrl credit_pool_assertions u_assertions (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // The watchdog is armed once the stim file has been read
  initial begin
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the operations did not complete within %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Lines that do not parse as three fields are the column notes
  task automatic load_stim(output bit ok);
    int    fd;
    int    arg;
    int    idle;
    int    max_idle;
    int    ops;
    byte   op;
    string line;
    ok       = 1'b0;
    max_idle = 0;
    ops      = 0;
    fd = $fopen("testbench/credit_pool_stim.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) > 0) begin
      if ($sscanf(line, "%c %d %d", op, arg, idle) == 3) begin
        op_q.push_back(op);
        arg_q.push_back(arg);
        idle_q.push_back(idle);
        max_idle = (idle > max_idle) ? idle : max_idle;
        ops += (op == "A") ? arg : ((op == "B") ? 2 : 1);
      end
    end
    $fclose(fd);
    // A full handshake needs about four cycles past its idle gap
    cycle_limit = reset_cycles + 4 + ops * (max_idle + 6);
    ok = (op_q.size() > 0);
  endtask

  // Hold each request until its ack, then wait for the ack to drop
  task automatic complete_release();
    do @(negedge clk); while (!release_ack);
    release_req = 1'b0;
    do @(negedge clk); while (release_ack);
  endtask

  task automatic complete_alloc();
    do @(negedge clk); while (!alloc_ack);
    alloc_req = 1'b0;
    do @(negedge clk); while (alloc_ack);
  endtask

  // A repeats an allocation arg times, B raises a release and an allocation together
  task automatic run_op(input byte op, input int arg, input int idle);
    int reps;
    reps = (op == "A") ? arg : 1;
    for (int r = 0; r < reps; r++) begin
      repeat (idle) @(negedge clk);
      @(negedge clk);
      if (op != "A") begin
        release_info.idx = idx_width'(arg);
        release_req      = 1'b1;
      end
      if (op != "R") alloc_req = 1'b1;
      if (op != "A") complete_release();
      if (op != "R") complete_alloc();
    end
  endtask

  task automatic report_result();
    int assert_count;
    assert_count = u_dut.u_ctrl.u_assertions.fail_count;
    $display("Errors: %0d mismatch, %0d protocol, %0d assertion",
             mismatch_count, protocol_count, assert_count);
    if (mismatch_count + protocol_count + assert_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    bit stim_ok;
    rst_n        = 1'b0;
    alloc_req    = 1'b0;
    release_req  = 1'b0;
    release_info = '0;
    load_stim(stim_ok);
    if (!stim_ok) begin
      $display("Could not read any operation from the stim file");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      foreach (op_q[i]) run_op(op_q[i], arg_q[i], idle_q[i]);
      repeat (2) @(negedge clk);
      report_result();
    end
  end

endmodule

// File: testbench/credit_pool_stim.txt
# op idx_or_count idle : A = allocate <count> times, R = release to list <idx>,
# B = release to list <idx> raised together with one allocate; idle cycles come first
A 8 0
A 8 2
A 16 0
A 1 1
R 5 0
A 1 3
R 2 0
R 2 1
A 2 0
R 6 0
R 3 4
A 2 0
R 7 0
R 4 0
B 4 2
A 2 1
A 1 0

// File: vlog.f
hw/credit_sizing_pkg.sv
hw/credit_xact_pkg.sv
hw/freelist_select.sv
hw/freelist_counters.sv
hw/credit_grant_ctrl.sv
hw/credit_pool_top.sv
testbench/credit_pool_assertions.sv
testbench/credit_pool_checker.sv
testbench/credit_pool_tb.sv

// File: Bender.yml
package:
  name: credit_pool

sources:
  - files:
      - hw/credit_sizing_pkg.sv
      - hw/credit_xact_pkg.sv
      - hw/freelist_select.sv
      - hw/freelist_counters.sv
      - hw/credit_grant_ctrl.sv
      - hw/credit_pool_top.sv
  - target: test
    files:
      - testbench/credit_pool_assertions.sv
      - testbench/credit_pool_checker.sv
      - testbench/credit_pool_tb.sv
